// ==== list.f ====
verilog/cipher_pkg.sv
verilog/mem_pkg.sv
verilog/sbox_ram.sv
verilog/msg_ram.sv
verilog/key_schedule.sv
verilog/prga.sv
verilog/arc4_ctrl.sv
verilog/arc4.sv
bench/tb_clock.sv
bench/tb_arc4.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_arc4
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

PASS_MSG := All tests passed!
SRCS     := $(wildcard verilog/*.sv) $(wildcard bench/*.sv)
DATA     := bench/arc4_input.hex
SIM      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM) $(DATA)
	./$(SIM) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

check: run
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/arc4_input.hex ====
// ARC4 vectors, every value is one hex byte
// Per vector: key[23:16] key[15:8] key[7:0] L, then L ciphertext bytes, then L plaintext bytes
03
// "Plaintext" under key "Key"
4B 65 79 09
BB F3 16 E8 D9 40 AF 0A D3
50 6C 61 69 6E 74 65 78 74
// Single byte message
4B 65 79 01
BB
50
// "Hello" under key "Key"
4B 65 79 05
A3 FA 1B ED D8
48 65 6C 6C 6F

// ==== bench/tb_arc4.sv ====
`timescale 1ns/1ps

module tb_arc4
	import cipher_pkg::*;
	import mem_pkg::*;
();

	localparam int          MAX_JOBS    = 16;
	localparam int          BASE_CYCLES = 2000;
	localparam int          JOB_CYCLES  = 1500;   // Key schedule and handshake
	localparam int          BYTE_CYCLES = 12;
	localparam logic [31:0] LFSR_SEED   = 32'd72798;
	localparam logic [31:0] LFSR_TAPS   = 32'h80200003;

	logic        clk;
	logic        rst_n;
	logic        start_valid;
	logic        start_ready;
	key_t        key;
	logic        ct_wren;
	addr_t       ct_addr;
	byte_t       ct_wrdata;
	addr_t       pt_addr;
	byte_t       pt_rddata;

	byte_t       vec_mem [4096];
	byte_t       job_ct [MAX_JOBS][256];
	byte_t       job_pt [MAX_JOBS][256];
	key_t        job_key [MAX_JOBS];
	int          job_len [MAX_JOBS];
	int          order [MAX_JOBS];
	byte_t       ks_buf [256];
	int          num_jobs;
	int          budget;
	int          errors;
	int          checks;
	int          accepts;
	logic [31:0] lfsr;

	tb_clock clock_gen (.clk_o(clk), .rst_n_o(rst_n));

	arc4 uut (
		.clk, .rst_n, .start_valid_i(start_valid), .start_ready_o(start_ready), .key_i(key),
		.ct_wren_i(ct_wren), .ct_addr_i(ct_addr), .ct_wrdata_i(ct_wrdata),
		.pt_addr_i(pt_addr), .pt_rddata_o(pt_rddata)
	);

	// ========================================
	// Random bits and reference keystream
	// ========================================

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int b = 0; b < n; b++) begin
			val  = {val[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
		end
		return val;
	endfunction

	// Textbook RC4 with keystream bytes in ks_buf[1..len]
	function automatic void make_keystream(input key_t k, input int len);
		int s [256];
		int i;
		int j;
		int t;
		for (int n = 0; n < 256; n++) begin
			s[n] = n;
		end
		j = 0;
		for (int n = 0; n < 256; n++) begin
			t    = int'((k >> (8 * (KEY_BYTES - 1 - n % KEY_BYTES))) & 24'hFF);
			j    = (j + s[n] + t) % 256;
			t    = s[n];
			s[n] = s[j];
			s[j] = t;
		end
		i = 0;
		j = 0;
		for (int m = 1; m <= len; m++) begin
			i         = (i + 1) % 256;
			j         = (j + s[i]) % 256;
			t         = s[i];
			s[i]      = s[j];
			s[j]      = t;
			ks_buf[m] = byte_t'(s[(s[i] + s[j]) % 256]);
		end
	endfunction

	// ========================================
	// Job list
	// ========================================

	task automatic load_file_vectors();
		int cnt;
		int pos;
		int n;
		$readmemh("bench/arc4_input.hex", vec_mem);
		cnt = int'(vec_mem[0]);
		pos = 1;
		if (cnt == 0 || 2 * cnt + 4 > MAX_JOBS) begin
			errors++;
			$display("Vector file gives an unusable vector count of %0d", cnt);
			cnt = 0;
		end
		for (int v = 0; v < cnt; v++) begin
			n            = num_jobs;
			job_key[n]   = {vec_mem[pos], vec_mem[pos + 1], vec_mem[pos + 2]};
			job_len[n]   = int'(vec_mem[pos + 3]);
			job_ct[n][0] = vec_mem[pos + 3];
			job_pt[n][0] = vec_mem[pos + 3];
			pos          = pos + 4;
			for (int m = 1; m <= job_len[n]; m++) begin
				job_ct[n][m] = vec_mem[pos + m - 1];
				job_pt[n][m] = vec_mem[pos + job_len[n] + m - 1];
			end
			pos = pos + 2 * job_len[n];
			make_keystream(job_key[n], job_len[n]);
			for (int m = 1; m <= job_len[n]; m++) begin
				checks++;
				if ((job_ct[n][m] ^ job_pt[n][m]) != ks_buf[m]) begin
					errors++;
					$display("Reference keystream disagrees with file vector %0d at byte %0d", v, m);
				end
			end
			// Same key run backwards with plaintext in and ciphertext out
			job_key[n + 1] = job_key[n];
			job_len[n + 1] = job_len[n];
			for (int m = 0; m <= job_len[n]; m++) begin
				job_ct[n + 1][m] = job_pt[n][m];
				job_pt[n + 1][m] = job_ct[n][m];
			end
			num_jobs = num_jobs + 2;
		end
	endtask

	task automatic add_random_vector(input int len);
		int n;
		n            = num_jobs;
		job_key[n]   = key_t'(rand_bits(24));
		job_len[n]   = len;
		job_ct[n][0] = byte_t'(len);
		job_pt[n][0] = byte_t'(len);
		make_keystream(job_key[n], len);
		for (int m = 1; m <= len; m++) begin
			job_pt[n][m] = byte_t'(rand_bits(8));
			job_ct[n][m] = job_pt[n][m] ^ ks_buf[m];
		end
		num_jobs++;
	endtask

	task automatic shuffle_jobs();
		int j;
		int t;
		for (int m = 0; m < num_jobs; m++) begin
			order[m] = m;
		end
		for (int m = num_jobs - 1; m > 0; m--) begin
			j        = int'(rand_bits(8)) % (m + 1);
			t        = order[m];
			order[m] = order[j];
			order[j] = t;
		end
	endtask

	// ========================================
	// Host side of one job
	// ========================================

	task automatic read_pt(input addr_t addr, output byte_t data);
		@(posedge clk);
		pt_addr <= addr;
		@(posedge clk);
		@(negedge clk);
		data = pt_rddata;                    // One cycle read latency
	endtask

	task automatic run_job(input int n);
		byte_t got;
		int    hold;
		repeat (int'(rand_bits(4))) @(posedge clk);
		for (int a = 0; a <= job_len[n]; a++) begin
			@(posedge clk);
			ct_wren   <= 1'b1;
			ct_addr   <= addr_t'(a);
			ct_wrdata <= job_ct[n][a];
		end
		@(posedge clk);
		ct_wren     <= 1'b0;
		start_valid <= 1'b1;
		key         <= job_key[n];
		hold = (rand_bits(1) != 0) ? int'(rand_bits(8)) + 1 : 0;
		@(negedge clk);
		while (!start_ready) @(negedge clk);
		@(posedge clk);                      // Handshake edge
		key <= key_t'(rand_bits(24));        // Core must work from its latched copy
		if (hold == 0) begin
			start_valid <= 1'b0;
		end else begin
			repeat (hold) begin
				@(negedge clk);
				checks++;
				if (start_ready !== 1'b0) begin
					errors++;
					$display("** Error: start_ready_o in job %0d: got %h, expected %h",
						n, start_ready, 1'b0);
				end
			end
			@(posedge clk);
			start_valid <= 1'b0;
		end
		@(negedge clk);
		while (!start_ready) @(negedge clk);
		read_pt(LEN_ADDR, got);
		checks++;
		if (got !== byte_t'(job_len[n])) begin
			errors++;
			$display("** Error: pt_rddata_o at pt[0], job %0d: got %h, expected %h",
				n, got, byte_t'(job_len[n]));
		end
		for (int a = 1; a <= job_len[n]; a++) begin
			read_pt(addr_t'(a), got);
			checks++;
			if (got !== job_pt[n][a]) begin
				errors++;
				$display("** Error: pt_rddata_o at pt[%0d], job %0d: got %h, expected %h",
					a, n, got, job_pt[n][a]);
			end
		end
	endtask

	// ========================================
	// Main sequence and watchdog
	// ========================================

	always @(negedge clk) begin
		if (rst_n && start_valid && start_ready) begin
			accepts++;                       // Taken on the next rising edge
		end
	end

	initial begin
		start_valid = 1'b0;
		key         = '0;
		ct_wren     = 1'b0;
		ct_addr     = '0;
		ct_wrdata   = '0;
		pt_addr     = '0;
		errors      = 0;
		checks      = 0;
		accepts     = 0;
		num_jobs    = 0;
		budget      = 0;
		lfsr        = LFSR_SEED;
		load_file_vectors();
		add_random_vector(255);
		add_random_vector(1);
		add_random_vector(2 + int'(rand_bits(7)));
		add_random_vector(2 + int'(rand_bits(7)));
		shuffle_jobs();
		budget = BASE_CYCLES;
		for (int n = 0; n < num_jobs; n++) begin
			budget = budget + JOB_CYCLES + BYTE_CYCLES * (job_len[n] + 1);
		end
		wait (rst_n);
		@(negedge clk);
		checks++;
		if (start_ready !== 1'b1) begin
			errors++;
			$display("** Error: start_ready_o after reset: got %h, expected %h",
				start_ready, 1'b1);
		end
		for (int n = 0; n < num_jobs; n++) begin
			run_job(order[n]);
		end
		checks++;
		if (accepts != num_jobs) begin
			errors++;
			$display("DUT took %0d start handshakes for %0d jobs", accepts, num_jobs);
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		wait (rst_n);                        // Budget is complete before reset ends
		repeat (budget) @(posedge clk);
		$display("Timeout: jobs still running after %0d clock cycles", budget);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("Test failures found");
		$finish;
	end

endmodule : tb_arc4

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk_o,
	output logic rst_n_o
);

	localparam int RESET_CYCLES = 3;

	initial begin
		clk_o = 1'b0;
		forever #50 clk_o = ~clk_o;          // 100 ns period
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;                      // Release away from the active edge
	end

endmodule : tb_clock

// ==== verilog/arc4.sv ====
`timescale 1ns/1ps

module arc4
	import cipher_pkg::*;
	import mem_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  start_valid_i,
	output logic  start_ready_o,
	input  key_t  key_i,
	input  logic  ct_wren_i,
	input  addr_t ct_addr_i,
	input  byte_t ct_wrdata_i,
	input  addr_t pt_addr_i,
	output byte_t pt_rddata_o
);

	key_t  key;
	logic  ks_en;
	logic  ks_rdy;
	logic  pr_en;
	logic  pr_rdy;
	addr_t ks_s_addr;
	byte_t ks_s_wrdata;
	logic  ks_s_wren;
	addr_t pr_s_addr;
	byte_t pr_s_wrdata;
	logic  pr_s_wren;
	addr_t s_addr;
	byte_t s_wrdata;
	logic  s_wren;
	byte_t s_rddata;
	addr_t ct_addr;
	byte_t ct_rddata;
	addr_t pt_addr;
	byte_t pt_rddata;
	byte_t pt_wrdata;
	logic  pt_wren;

	arc4_ctrl ctrl (
		.clk, .rst_n, .start_valid_i, .start_ready_o, .key_i,
		.key_o(key), .ks_en_o(ks_en), .ks_rdy_i(ks_rdy), .pr_en_o(pr_en), .pr_rdy_i(pr_rdy),
		.ks_s_addr_i(ks_s_addr), .ks_s_wrdata_i(ks_s_wrdata), .ks_s_wren_i(ks_s_wren),
		.pr_s_addr_i(pr_s_addr), .pr_s_wrdata_i(pr_s_wrdata), .pr_s_wren_i(pr_s_wren),
		.s_addr_o(s_addr), .s_wrdata_o(s_wrdata), .s_wren_o(s_wren)
	);

	key_schedule ks (
		.clk, .rst_n, .en_i(ks_en), .rdy_o(ks_rdy), .key_i(key),
		.s_addr_o(ks_s_addr), .s_rddata_i(s_rddata), .s_wrdata_o(ks_s_wrdata),
		.s_wren_o(ks_s_wren)
	);

	prga pr (
		.clk, .rst_n, .en_i(pr_en), .rdy_o(pr_rdy),
		.s_addr_o(pr_s_addr), .s_rddata_i(s_rddata), .s_wrdata_o(pr_s_wrdata),
		.s_wren_o(pr_s_wren), .ct_addr_o(ct_addr), .ct_rddata_i(ct_rddata),
		.pt_addr_o(pt_addr), .pt_rddata_i(pt_rddata), .pt_wrdata_o(pt_wrdata),
		.pt_wren_o(pt_wren)
	);

	sbox_ram s_mem (
		.clk, .addr_i(s_addr), .wrdata_i(s_wrdata), .wren_i(s_wren), .rddata_o(s_rddata)
	);

	// Core reads on a, host writes on b
	msg_ram ct_mem (
		.clk,
		.a_addr_i(ct_addr), .a_wrdata_i(8'd0), .a_wren_i(1'b0), .a_rddata_o(ct_rddata),
		.b_addr_i(ct_addr_i), .b_wrdata_i(ct_wrdata_i), .b_wren_i(ct_wren_i), .b_rddata_o()
	);

	// Core writes on a, host reads on b
	msg_ram pt_mem (
		.clk,
		.a_addr_i(pt_addr), .a_wrdata_i(pt_wrdata), .a_wren_i(pt_wren), .a_rddata_o(pt_rddata),
		.b_addr_i(pt_addr_i), .b_wrdata_i(8'd0), .b_wren_i(1'b0), .b_rddata_o(pt_rddata_o)
	);

	// Ciphertext is only loaded between jobs
	assert property (@(posedge clk) disable iff (!rst_n) !start_ready_o |-> !ct_wren_i);

endmodule : arc4

// ==== verilog/arc4_ctrl.sv ====
`timescale 1ns/1ps

module arc4_ctrl
	import cipher_pkg::*;
	import mem_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  start_valid_i,
	output logic  start_ready_o,
	input  key_t  key_i,
	output key_t  key_o,
	output logic  ks_en_o,
	input  logic  ks_rdy_i,
	output logic  pr_en_o,
	input  logic  pr_rdy_i,
	input  addr_t ks_s_addr_i,
	input  byte_t ks_s_wrdata_i,
	input  logic  ks_s_wren_i,
	input  addr_t pr_s_addr_i,
	input  byte_t pr_s_wrdata_i,
	input  logic  pr_s_wren_i,
	output addr_t s_addr_o,
	output byte_t s_wrdata_o,
	output logic  s_wren_o
);

	typedef enum logic [1:0] {
		st_idle,
		st_schedule,
		st_generate
	} state_t;

	state_t state;
	logic   pr_sel;                          // PRGA owns the S port

	assign start_ready_o = (state == st_idle);
	assign pr_sel        = (state == st_generate);

	assign s_addr_o   = pr_sel ? pr_s_addr_i : ks_s_addr_i;
	assign s_wrdata_o = pr_sel ? pr_s_wrdata_i : ks_s_wrdata_i;
	assign s_wren_o   = pr_sel ? pr_s_wren_i : ks_s_wren_i;

	// Engine rdy is stale while its en pulse is out
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= st_idle;
			ks_en_o <= 1'b0;
			pr_en_o <= 1'b0;
		end else begin
			ks_en_o <= 1'b0;
			pr_en_o <= 1'b0;
			case (state)
				st_idle: begin
					if (start_valid_i) begin
						state   <= st_schedule;
						ks_en_o <= 1'b1;
					end
				end
				st_schedule: begin
					if (!ks_en_o && ks_rdy_i) begin
						state   <= st_generate;
						pr_en_o <= 1'b1;
					end
				end
				st_generate: begin
					if (!pr_en_o && pr_rdy_i) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start_valid_i && start_ready_o) begin
			key_o <= key_i;
		end
	end

	// Idle engine keeps off the S memory
	assert property (@(posedge clk) disable iff (!rst_n)
		pr_sel ? !ks_s_wren_i : !pr_s_wren_i);

endmodule : arc4_ctrl

// ==== verilog/prga.sv ====
`timescale 1ns/1ps

module prga
	import cipher_pkg::*;
	import mem_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  en_i,
	output logic  rdy_o,
	output addr_t s_addr_o,
	input  byte_t s_rddata_i,
	output byte_t s_wrdata_o,
	output logic  s_wren_o,
	output addr_t ct_addr_o,
	input  byte_t ct_rddata_i,
	output addr_t pt_addr_o,
	input  byte_t pt_rddata_i,
	output byte_t pt_wrdata_o,
	output logic  pt_wren_o
);

	typedef enum logic [3:0] {
		st_idle,
		st_ld_len,
		st_rd_len,
		st_inc_i,
		st_calc_j,
		st_wr_j,
		st_wr_i,
		st_ld_pad,
		st_wr_pad,
		st_wr_len,
		st_ld_k,
		st_xor_pt
	} state_t;

	state_t state;
	addr_t  i;
	addr_t  j;
	addr_t  i_n;
	addr_t  j_n;
	addr_t  pad_idx;
	addr_t  k_addr;
	byte_t  k;                               // Message byte index
	byte_t  msglen;
	byte_t  sti;
	byte_t  stj;
	logic   last;

	assign i_n     = i + 1'b1;
	assign j_n     = addr_t'((j + s_rddata_i) % S_SIZE);
	assign pad_idx = addr_t'((sti + stj) % S_SIZE);
	assign k_addr  = k + 8'd1;               // Data starts after the length byte
	assign last    = (k == msglen - 8'd1);

	always_comb begin
		rdy_o       = 1'b0;
		s_addr_o    = i;
		s_wrdata_o  = '0;
		s_wren_o    = 1'b0;
		ct_addr_o   = k_addr;
		pt_addr_o   = k_addr;
		pt_wrdata_o = '0;
		pt_wren_o   = 1'b0;
		case (state)
			st_idle:   rdy_o = 1'b1;
			st_ld_len: ct_addr_o = LEN_ADDR;
			st_inc_i:  s_addr_o = i_n;
			st_calc_j: s_addr_o = j_n;
			st_wr_j: begin
				s_addr_o   = j;
				s_wrdata_o = sti;
				s_wren_o   = 1'b1;
			end
			st_wr_i: begin
				s_wrdata_o = stj;
				s_wren_o   = 1'b1;
			end
			st_ld_pad: s_addr_o = pad_idx;
			st_wr_pad: begin
				pt_wrdata_o = s_rddata_i;    // Keystream byte
				pt_wren_o   = 1'b1;
			end
			st_wr_len: begin
				pt_addr_o   = LEN_ADDR;
				pt_wrdata_o = msglen;
				pt_wren_o   = 1'b1;
			end
			st_xor_pt: begin
				pt_wrdata_o = pt_rddata_i ^ ct_rddata_i;
				pt_wren_o   = 1'b1;
			end
			default: ;
		endcase
	end

	// ========================================
	// Keystream pass, then XOR pass
	// ========================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			i     <= '0;
			j     <= '0;
			k     <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (en_i) begin
						state <= st_ld_len;
					end
					i <= '0;
					j <= '0;
					k <= '0;
				end
				st_ld_len: state <= st_rd_len;
				st_rd_len: state <= st_inc_i;
				st_inc_i: begin
					i     <= i_n;
					state <= st_calc_j;
				end
				st_calc_j: begin
					j     <= j_n;
					state <= st_wr_j;
				end
				st_wr_j:   state <= st_wr_i;
				st_wr_i:   state <= st_ld_pad;
				st_ld_pad: state <= st_wr_pad;
				st_wr_pad: begin
					k     <= last ? 8'd0 : k + 8'd1;
					state <= last ? st_wr_len : st_inc_i;
				end
				st_wr_len: state <= st_ld_k;
				st_ld_k:   state <= st_xor_pt;
				st_xor_pt: begin
					k     <= k + 8'd1;
					state <= last ? st_idle : st_ld_k;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_rd_len) begin
			msglen <= ct_rddata_i;
		end
		if (state == st_calc_j) begin
			sti <= s_rddata_i;
		end
		if (state == st_wr_j) begin
			stj <= s_rddata_i;
		end
	end

	// Host must not load an empty message
	assert property (@(posedge clk) disable iff (!rst_n)
		(state == st_rd_len) |-> (ct_rddata_i != 8'd0));

endmodule : prga

// ==== verilog/key_schedule.sv ====
`timescale 1ns/1ps

module key_schedule
	import cipher_pkg::*;
	import mem_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  en_i,
	output logic  rdy_o,
	input  key_t  key_i,
	output addr_t s_addr_o,
	input  byte_t s_rddata_i,
	output byte_t s_wrdata_o,
	output logic  s_wren_o
);

	typedef enum logic [2:0] {
		st_idle,
		st_fill,
		st_read_i,
		st_calc_j,
		st_write_j,
		st_write_i
	} state_t;

	state_t     state;
	addr_t      i;
	addr_t      j;
	addr_t      j_n;
	byte_t      si;
	byte_t      sj;
	byte_t      kbyte;
	logic [1:0] kidx;                        // i mod KEY_BYTES

	assign kbyte = key_i[8 * (KEY_BYTES - 1 - kidx) +: 8];
	assign j_n   = addr_t'((j + s_rddata_i + kbyte) % S_SIZE);   // S[i] valid in calc_j

	always_comb begin
		rdy_o      = 1'b0;
		s_addr_o   = i;
		s_wrdata_o = '0;
		s_wren_o   = 1'b0;
		case (state)
			st_idle:   rdy_o = 1'b1;
			st_fill: begin
				s_wrdata_o = i;              // Identity permutation
				s_wren_o   = 1'b1;
			end
			st_calc_j: s_addr_o = j_n;
			st_write_j: begin
				s_addr_o   = j;
				s_wrdata_o = si;
				s_wren_o   = 1'b1;
			end
			st_write_i: begin
				s_wrdata_o = sj;
				s_wren_o   = 1'b1;
			end
			default: ;
		endcase
	end

	// ========================================
	// Fill, then 4 cycles per shuffle step
	// ========================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			i     <= '0;
			j     <= '0;
			kidx  <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (en_i) begin
						state <= st_fill;
					end
					i    <= '0;
					j    <= '0;
					kidx <= '0;
				end
				st_fill: begin
					i <= i + 1'b1;           // Wraps to 0 for the shuffle
					if (i == addr_t'(S_SIZE - 1)) begin
						state <= st_read_i;
					end
				end
				st_read_i:  state <= st_calc_j;
				st_calc_j: begin
					j     <= j_n;
					state <= st_write_j;
				end
				st_write_j: state <= st_write_i;
				st_write_i: begin
					i     <= i + 1'b1;
					kidx  <= (kidx == 2'(KEY_BYTES - 1)) ? 2'd0 : kidx + 2'd1;
					state <= (i == addr_t'(S_SIZE - 1)) ? st_idle : st_read_i;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_calc_j) begin
			si <= s_rddata_i;
		end
		if (state == st_write_j) begin
			sj <= s_rddata_i;                // Old S[j], read issued in calc_j
		end
	end

	// Controller never restarts a busy engine
	assert property (@(posedge clk) disable iff (!rst_n) en_i |-> rdy_o);

endmodule : key_schedule

// ==== verilog/msg_ram.sv ====
`timescale 1ns/1ps

module msg_ram
	import mem_pkg::*;
(
	input  logic  clk,
	// Port a
	input  addr_t a_addr_i,
	input  byte_t a_wrdata_i,
	input  logic  a_wren_i,
	output byte_t a_rddata_o,
	// Port b
	input  addr_t b_addr_i,
	input  byte_t b_wrdata_i,
	input  logic  b_wren_i,
	output byte_t b_rddata_o
);

	byte_t mem [MEM_DEPTH];

	always_ff @(posedge clk) begin
		if (a_wren_i) begin
			mem[a_addr_i] <= a_wrdata_i;
		end
		if (b_wren_i) begin
			mem[b_addr_i] <= b_wrdata_i;     // Port b wins on a collision
		end
		a_rddata_o <= mem[a_addr_i];
		b_rddata_o <= mem[b_addr_i];
	end

endmodule : msg_ram

// ==== verilog/sbox_ram.sv ====
`timescale 1ns/1ps

module sbox_ram
	import mem_pkg::*;
(
	input  logic  clk,
	input  addr_t addr_i,
	input  byte_t wrdata_i,
	input  logic  wren_i,
	output byte_t rddata_o
);

	byte_t mem [MEM_DEPTH];                  // State array S

	always_ff @(posedge clk) begin
		if (wren_i) begin
			mem[addr_i] <= wrdata_i;
		end
		rddata_o <= mem[addr_i];             // Old data on a same-cycle write
	end

endmodule : sbox_ram

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

	// ========================================
	// Byte memories
	// ========================================

	typedef logic [7:0] addr_t;
	typedef logic [7:0] byte_t;

	localparam int    MEM_DEPTH = 256;
	localparam addr_t LEN_ADDR  = 8'd0;      // Message length byte

endpackage : mem_pkg

// ==== verilog/cipher_pkg.sv ====
package cipher_pkg;

	// ========================================
	// Key and state array
	// ========================================

	typedef logic [23:0] key_t;              // Key byte 0 sits in [23:16]

	localparam int KEY_BYTES = 3;            // Bytes used in rotation by the shuffle
	localparam int S_SIZE    = 256;          // Entries in S

endpackage : cipher_pkg
